/* hw/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

	// ##################################################
	// Widths and constants
	// ##################################################

	localparam int xlen           = 32;
	localparam int mem_words      = 1024;
	localparam int mem_index_bits = 10; // Word index into the SRAM
	localparam logic [1:0] resp_okay = 2'b00;

	typedef logic [xlen-1:0]     word_t;
	typedef logic [xlen-1:0]     addr_t;
	typedef logic [xlen/8-1:0]   strb_t;
	typedef logic [2:0]          funct3_t;
	typedef logic [1:0]          resp_t;
	typedef logic [2:0]          size_t;

	typedef enum logic [1:0] {
		st_idle,
		st_read,
		st_write,
		st_wb // Writeback cycle that also takes the next request
	} lsu_state_t;

	// ##################################################
	// Request and bus channel payloads
	// ##################################################

	typedef struct packed {
		word_t   val;        // Address for loads and stores and the result for a pass-through
		word_t   store_data;
		funct3_t funct3;
		logic    ren;
		logic    wen;
	} lsu_req_t;

	typedef struct packed {
		addr_t addr;
		size_t size;
	} bus_ar_t;

	typedef struct packed {
		addr_t addr;
		size_t size;
	} bus_aw_t;

	typedef struct packed {
		word_t data;
		strb_t strb;
	} bus_w_t;

	typedef struct packed {
		word_t data;
		resp_t resp;
	} bus_r_t;

	typedef struct packed {
		resp_t resp;
	} bus_b_t;

endpackage

`default_nettype wire

/* hw/lsu_align.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_align (
	input  wire lsu_pkg::funct3_t funct3,
	input  wire logic [1:0]       addr_low,
	input  wire lsu_pkg::word_t   store_data,
	input  wire lsu_pkg::word_t   rdata,
	output lsu_pkg::word_t        wdata,
	output lsu_pkg::strb_t        wstrb,
	output lsu_pkg::word_t        load_val
);

	lsu_pkg::strb_t base_mask;
	lsu_pkg::word_t rdata_shift;
	logic [4:0]     bit_offset;

	assign bit_offset = {addr_low, 3'b000};

	always_comb begin
		case (funct3[1:0])
			2'b00:   base_mask = 4'b0001;
			2'b01:   base_mask = 4'b0011;
			2'b10:   base_mask = 4'b1111;
			default: base_mask = 4'b0000;
		endcase
	end

	// Store lanes move up by the byte offset
	assign wstrb = base_mask << addr_low;
	assign wdata = store_data << bit_offset;

	assign rdata_shift = rdata >> bit_offset; // Selected lane lands at bit 0

	always_comb begin
		case (funct3)
			3'b000:  load_val = {{24{rdata_shift[7]}}, rdata_shift[7:0]};   // lb
			3'b001:  load_val = {{16{rdata_shift[15]}}, rdata_shift[15:0]}; // lh
			3'b010:  load_val = rdata_shift;                                 // lw
			3'b100:  load_val = {24'h0, rdata_shift[7:0]};                   // lbu
			3'b101:  load_val = {16'h0, rdata_shift[15:0]};                  // lhu
			default: load_val = '0;
		endcase
	end

endmodule

`default_nettype wire

/* hw/lsu_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_stage (
	input  wire                    clock,
	input  wire                    rst_n,
	input  wire                    flush,

	input  wire lsu_pkg::lsu_req_t req,
	input  wire                    req_valid,
	output logic                   req_ready,

	output lsu_pkg::bus_ar_t       ar,
	output logic                   arvalid,
	input  wire                    arready,
	input  wire lsu_pkg::bus_r_t   r,
	input  wire                    rvalid,
	output logic                   rready,

	output lsu_pkg::bus_aw_t       aw,
	output logic                   awvalid,
	input  wire                    awready,
	output lsu_pkg::bus_w_t        w,
	output logic                   wvalid,
	input  wire                    wready,
	input  wire lsu_pkg::bus_b_t   b,
	input  wire                    bvalid,
	output logic                   bready,

	output lsu_pkg::word_t         wb_val,
	output logic                   wb_valid
);

	lsu_pkg::lsu_state_t state;
	lsu_pkg::addr_t      addr_q;
	lsu_pkg::funct3_t    funct3_q;
	lsu_pkg::word_t      store_data_q;
	lsu_pkg::word_t      wdata;
	lsu_pkg::strb_t      wstrb;
	lsu_pkg::word_t      load_val;
	lsu_pkg::size_t      size;

	logic idle;
	logic accept;
	logic start_read;
	logic start_write;
	logic ar_fire;
	logic aw_fire;
	logic w_fire;
	logic r_fire;
	logic b_fire;

	// ##################################################
	// Handshakes
	// ##################################################

	assign idle      = (state == lsu_pkg::st_idle) || (state == lsu_pkg::st_wb);
	assign req_ready = idle & ~flush; // A flush from the branch unit blocks new work
	assign accept    = req_valid & req_ready;

	assign start_read  = accept & req.ren;
	assign start_write = accept & req.wen & ~req.ren;

	assign ar_fire = arvalid & arready;
	assign aw_fire = awvalid & awready;
	assign w_fire  = wvalid & wready;
	assign r_fire  = rvalid & rready;
	assign b_fire  = bvalid & bready;

	assign rready   = 1'b1;
	assign bready   = 1'b1;
	assign wb_valid = (state == lsu_pkg::st_wb);

	// Bus payloads come from the request held since accept
	assign size = {1'b0, funct3_q[1:0]};
	assign ar   = '{addr: addr_q, size: size};
	assign aw   = '{addr: addr_q, size: size};
	assign w    = '{data: wdata, strb: wstrb};

	lsu_align align (
		.funct3    (funct3_q),
		.addr_low  (addr_q[1:0]),
		.store_data(store_data_q),
		.rdata     (r.data),
		.wdata     (wdata),
		.wstrb     (wstrb),
		.load_val  (load_val)
	);

	// ##################################################
	// Control state
	// ##################################################

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state <= lsu_pkg::st_idle;
		end else begin
			case (state)
				lsu_pkg::st_idle, lsu_pkg::st_wb: begin
					if (start_read)       state <= lsu_pkg::st_read;
					else if (start_write) state <= lsu_pkg::st_write;
					else if (accept)      state <= lsu_pkg::st_wb; // Pass-through
					else                  state <= lsu_pkg::st_idle;
				end
				lsu_pkg::st_read:  if (r_fire) state <= lsu_pkg::st_wb;
				lsu_pkg::st_write: if (b_fire) state <= lsu_pkg::st_wb;
				default:           state <= lsu_pkg::st_idle;
			endcase
		end
	end

	// Each valid drops on its own transfer
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			arvalid <= 1'b0;
			awvalid <= 1'b0;
			wvalid  <= 1'b0;
		end else begin
			if (start_read)   arvalid <= 1'b1;
			else if (ar_fire) arvalid <= 1'b0;

			if (start_write)  awvalid <= 1'b1;
			else if (aw_fire) awvalid <= 1'b0;

			if (start_write)  wvalid <= 1'b1;
			else if (w_fire)  wvalid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			addr_q       <= req.val;
			funct3_q     <= req.funct3;
			store_data_q <= req.store_data;
			wb_val       <= req.val; // Stores keep their address as the result
		end else if (r_fire) begin
			wb_val <= load_val;
		end
	end

endmodule

`default_nettype wire

/* hw/sram_slave.sv */
`timescale 1ns/1ps
`default_nettype none

module sram_slave (
	input  wire                   clock,
	input  wire                   rst_n,

	input  wire lsu_pkg::bus_ar_t ar,
	input  wire                   arvalid,
	output logic                  arready,
	output lsu_pkg::bus_r_t       r,
	output logic                  rvalid,
	input  wire                   rready,

	input  wire lsu_pkg::bus_aw_t aw,
	input  wire                   awvalid,
	output logic                  awready,
	input  wire lsu_pkg::bus_w_t  w,
	input  wire                   wvalid,
	output logic                  wready,
	output lsu_pkg::bus_b_t       b,
	output logic                  bvalid,
	input  wire                   bready
);

	lsu_pkg::word_t mem [lsu_pkg::mem_words];
	lsu_pkg::word_t rdata_q;

	logic [lsu_pkg::mem_index_bits-1:0] rd_index;
	logic [lsu_pkg::mem_index_bits-1:0] wr_index;

	logic ar_fire;
	logic wr_fire;
	logic r_fire;
	logic b_fire;

	// Addresses wrap on the memory size
	assign rd_index = ar.addr[lsu_pkg::mem_index_bits+1:2];
	assign wr_index = aw.addr[lsu_pkg::mem_index_bits+1:2];

	assign arready = ~rvalid; // Open whenever no read response is waiting
	assign awready = awvalid & wvalid & ~bvalid;
	assign wready  = awvalid & wvalid & ~bvalid;

	assign ar_fire = arvalid & arready;
	assign wr_fire = awvalid & awready & wvalid & wready;
	assign r_fire  = rvalid & rready;
	assign b_fire  = bvalid & bready;

	assign r = '{data: rdata_q, resp: lsu_pkg::resp_okay};
	assign b = '{resp: lsu_pkg::resp_okay};

	// ##################################################
	// Storage
	// ##################################################

	always_ff @(posedge clock) begin
		if (ar_fire) begin
			rdata_q <= mem[rd_index];
		end
		if (wr_fire) begin
			for (int i = 0; i < lsu_pkg::xlen / 8; i++) begin
				if (w.strb[i]) mem[wr_index][i*8 +: 8] <= w.data[i*8 +: 8];
			end
		end
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			rvalid <= 1'b0;
			bvalid <= 1'b0;
		end else begin
			if (ar_fire)     rvalid <= 1'b1;
			else if (r_fire) rvalid <= 1'b0;

			if (wr_fire)     bvalid <= 1'b1;
			else if (b_fire) bvalid <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* hw/lsu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
	input  wire                    clock,
	input  wire                    rst_n,
	input  wire                    flush,
	input  wire lsu_pkg::lsu_req_t req,
	input  wire                    req_valid,
	output logic                   req_ready,
	output lsu_pkg::word_t         wb_val,
	output logic                   wb_valid
);

	// Five channels between the stage and the memory
	lsu_pkg::bus_ar_t ar;
	lsu_pkg::bus_r_t  r;
	lsu_pkg::bus_aw_t aw;
	lsu_pkg::bus_w_t  w;
	lsu_pkg::bus_b_t  b;

	logic arvalid, arready;
	logic rvalid,  rready;
	logic awvalid, awready;
	logic wvalid,  wready;
	logic bvalid,  bready;

	lsu_stage stage (
		.clock    (clock),     .rst_n  (rst_n),   .flush  (flush),
		.req      (req),       .req_valid(req_valid), .req_ready(req_ready),
		.ar       (ar),        .arvalid(arvalid), .arready(arready),
		.r        (r),         .rvalid (rvalid),  .rready (rready),
		.aw       (aw),        .awvalid(awvalid), .awready(awready),
		.w        (w),         .wvalid (wvalid),  .wready (wready),
		.b        (b),         .bvalid (bvalid),  .bready (bready),
		.wb_val   (wb_val),    .wb_valid(wb_valid)
	);

	sram_slave memory (
		.clock  (clock),  .rst_n  (rst_n),
		.ar     (ar),     .arvalid(arvalid), .arready(arready),
		.r      (r),      .rvalid (rvalid),  .rready (rready),
		.aw     (aw),     .awvalid(awvalid), .awready(awready),
		.w      (w),      .wvalid (wvalid),  .wready (wready),
		.b      (b),      .bvalid (bvalid),  .bready (bready)
	);

endmodule

`default_nettype wire

/* verif/lsu_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_checker (
	input  wire                    clock,
	input  wire                    rst_n,
	input  wire                    flush,
	input  wire lsu_pkg::lsu_req_t req,
	input  wire                    req_valid,
	input  wire                    req_ready,
	input  wire lsu_pkg::word_t    wb_val,
	input  wire                    wb_valid,
	output int                     error_count
);

	lsu_pkg::word_t model [lsu_pkg::mem_words]; // Mirror of the SRAM contents
	lsu_pkg::word_t expected;
	logic           in_flight;
	logic [lsu_pkg::mem_index_bits-1:0] index;
	int             errors = 0;

	assign error_count = errors;

	// ##################################################
	// Reference rules for loads and stores
	// ##################################################

	function automatic lsu_pkg::word_t extract(input lsu_pkg::word_t data,
			input lsu_pkg::funct3_t f3, input logic [1:0] off);
		logic [7:0]     byte_v;
		logic [15:0]    half_v;
		lsu_pkg::word_t res;
		case (off)
			2'd0: byte_v = data[7:0];
			2'd1: byte_v = data[15:8];
			2'd2: byte_v = data[23:16];
			default: byte_v = data[31:24];
		endcase
		half_v = off[1] ? data[31:16] : data[15:0];
		case (f3)
			3'b000:  res = {{24{byte_v[7]}}, byte_v};
			3'b001:  res = {{16{half_v[15]}}, half_v};
			3'b010:  res = data;
			3'b100:  res = {24'h0, byte_v};
			3'b101:  res = {16'h0, half_v};
			default: res = '0; // Undefined width reads as zero
		endcase
		return res;
	endfunction

	function automatic lsu_pkg::word_t merge(input lsu_pkg::word_t old, input lsu_pkg::word_t data,
			input lsu_pkg::funct3_t f3, input logic [1:0] off);
		lsu_pkg::word_t res;
		res = old;
		case (f3[1:0])
			2'b00: begin
				case (off)
					2'd0: res[7:0] = data[7:0];
					2'd1: res[15:8] = data[7:0];
					2'd2: res[23:16] = data[7:0];
					default: res[31:24] = data[7:0];
				endcase
			end
			2'b01: begin
				if (off[1]) res[31:16] = data[15:0];
				else res[15:0] = data[15:0];
			end
			2'b10: res = data;
			default: res = old; // No lanes enabled
		endcase
		return res;
	endfunction

	always @(posedge clock) begin
		if (!rst_n) begin
			in_flight = 1'b0;
			expected = '0;
			for (int i = 0; i < lsu_pkg::mem_words; i++) model[i] = '0;
		end else begin
			if (wb_valid) begin
				if (!in_flight) begin
					$display("wb_valid pulsed with no request in flight at %0t", $time);
					errors++;
				end else if (wb_val !== expected) begin
					$display("[ERROR] wb_val = %h, expected %h", wb_val, expected);
					errors++;
				end
				in_flight = 1'b0;
			end
			if (flush && req_ready) begin
				$display("req_ready was high while flush was high at %0t", $time);
				errors++;
			end
			if (!in_flight && !flush && !req_ready) begin
				$display("req_ready was low with the stage idle at %0t", $time);
				errors++;
			end
			if (req_valid && req_ready) begin
				index = req.val[lsu_pkg::mem_index_bits+1:2];
				if (req.ren) begin
					expected = extract(model[index], req.funct3, req.val[1:0]);
				end else if (req.wen) begin
					model[index] = merge(model[index], req.store_data, req.funct3, req.val[1:0]);
					expected = req.val; // Stores write back their address
				end else begin
					expected = req.val;
				end
				in_flight = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* verif/tb_lsu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_lsu_top;

	logic              clock;
	logic              rst_n;
	logic              flush;
	lsu_pkg::lsu_req_t req;
	logic              req_valid;
	logic              req_ready;
	lsu_pkg::word_t    wb_val;
	logic              wb_valid;

	logic [31:0] lfsr;
	logic [31:0] rnd;
	int          check_errors;
	int          timeouts;

	localparam lsu_pkg::funct3_t load_codes [8] = '{3'b000, 3'b001, 3'b010, 3'b100,
		3'b101, 3'b010, 3'b000, 3'b100};

	always #50 clock = ~clock;

	lsu_top uut (
		.clock    (clock),
		.rst_n    (rst_n),
		.flush    (flush),
		.req      (req),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.wb_val   (wb_val),
		.wb_valid (wb_valid)
	);

	lsu_checker scoreboard (
		.clock      (clock),
		.rst_n      (rst_n),
		.flush      (flush),
		.req        (req),
		.req_valid  (req_valid),
		.req_ready  (req_ready),
		.wb_val     (wb_val),
		.wb_valid   (wb_valid),
		.error_count(check_errors)
	);

	// Taps 32, 22, 2 and 1 with one step per bit taken
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		logic        fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	// ##################################################
	// Request driving
	// ##################################################

	task automatic drive_request(input lsu_pkg::word_t val, input lsu_pkg::word_t data,
			input lsu_pkg::funct3_t f3, input logic ren, input logic wen);
		req.val = val;
		req.store_data = data;
		req.funct3 = f3;
		req.ren = ren;
		req.wen = wen;
		req_valid = 1'b1;
	endtask

	task automatic complete_request();
		int cycles;
		cycles = 0;
		while (!req_ready && cycles < 20) begin
			@(posedge clock);
			#10;
			cycles++;
		end
		if (!req_ready) begin
			$display("Timeout: req_ready stayed low for 20 cycles at %0t", $time);
			timeouts++;
			req_valid = 1'b0;
		end else begin
			@(posedge clock); // Accept edge
			#10;
			req_valid = 1'b0;
			cycles = 0;
			while (!wb_valid && cycles < 20) begin
				@(posedge clock);
				#10;
				cycles++;
			end
			if (!wb_valid) begin
				$display("Timeout: no wb_valid within 20 cycles of accept at %0t", $time);
				timeouts++;
			end
		end
	endtask

	task automatic run_request(input lsu_pkg::word_t val, input lsu_pkg::word_t data,
			input lsu_pkg::funct3_t f3, input logic ren, input logic wen);
		drive_request(val, data, f3, ren, wen);
		complete_request();
	endtask

	task automatic random_request();
		logic [1:0]       kind;
		logic [5:0]       index;
		logic [1:0]       off;
		lsu_pkg::funct3_t f3;
		lsu_pkg::word_t   data;
		rnd = random_bits(2);
		kind = rnd[1:0];
		rnd = random_bits(6);
		index = rnd[5:0];
		data = random_bits(32);
		rnd = random_bits(3);
		if (kind == 2'd2) f3 = {1'b0, (rnd[1:0] == 2'd3) ? 2'd2 : rnd[1:0]};
		else f3 = load_codes[rnd[2:0]];
		rnd = random_bits(2);
		case (f3[1:0])
			2'b00:   off = rnd[1:0];
			2'b01:   off = {rnd[1], 1'b0};
			default: off = 2'b00;
		endcase
		if (kind == 2'd0) run_request(data, 32'h0, f3, 1'b0, 1'b0); // Pass-through
		else if (kind == 2'd2) run_request({24'h0, index, off}, data, f3, 1'b0, 1'b1);
		else run_request({24'h0, index, off}, 32'h0, f3, 1'b1, 1'b0);
	endtask

	initial begin
		clock = 1'b0;
		rst_n = 1'b0;
		flush = 1'b0;
		req = '0;
		req_valid = 1'b0;
		lfsr = 32'ha5f16fb9;
		timeouts = 0;
		repeat (4) @(posedge clock);
		#10;
		rst_n = 1'b1;
		repeat (3) @(posedge clock); // Idle stage with nothing to write back
		#10;

		for (int i = 0; i < 64; i++) run_request(32'(i * 4), 32'h0, 3'b010, 1'b0, 1'b1);

		run_request(32'hdeadbeef, 32'h0, 3'b010, 1'b0, 1'b0);
		run_request(32'h00000000, 32'hffffffff, 3'b111, 1'b0, 1'b0);

		// Each store width into a known word and then a read of the whole word
		for (int k = 0; k < 4; k++) begin
			run_request(32'h40, 32'h11223344, 3'b010, 1'b0, 1'b1);
			run_request(32'(32'h40 + k), 32'h6b5a4d3c ^ 32'(k), 3'b000, 1'b0, 1'b1);
			run_request(32'h40, 32'h0, 3'b010, 1'b1, 1'b0);
			run_request(32'(32'h44 + (k & 2)), 32'h9e8d7c6b, 3'b001, 1'b0, 1'b1);
			run_request(32'h44, 32'h0, 3'b010, 1'b1, 1'b0);
		end
		run_request(32'h48, 32'hc3d2e1f0, 3'b010, 1'b0, 1'b1);
		run_request(32'h48, 32'h0, 3'b010, 1'b1, 1'b0);

		// Signed and unsigned narrow loads
		run_request(32'h50, 32'h80f17f01, 3'b010, 1'b0, 1'b1);
		for (int k = 0; k < 4; k++) begin
			run_request(32'(32'h50 + k), 32'h0, 3'b000, 1'b1, 1'b0);
			run_request(32'(32'h50 + k), 32'h0, 3'b100, 1'b1, 1'b0);
			run_request(32'(32'h50 + (k & 2)), 32'h0, 3'b001, 1'b1, 1'b0);
			run_request(32'(32'h50 + (k & 2)), 32'h0, 3'b101, 1'b1, 1'b0);
		end

		// Held request under flush
		flush = 1'b1;
		drive_request(32'h50, 32'h0, 3'b010, 1'b1, 1'b0);
		repeat (5) @(posedge clock);
		#10;
		flush = 1'b0;
		complete_request();

		repeat (400) random_request();
		repeat (2) @(posedge clock);
		#10;

		$display("Errors: %0d from checker, %0d timeouts", check_errors, timeouts);
		if (check_errors == 0 && timeouts == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
hw/lsu_pkg.sv
hw/lsu_align.sv
hw/lsu_stage.sv
hw/sram_slave.sv
hw/lsu_top.sv
verif/lsu_checker.sv
verif/tb_lsu_top.sv

/* run.sh */
#!/bin/sh
# Build and run the load/store stage testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_lsu_top -f verilog.f -o tb_sim
./obj_dir/tb_sim | tee sim.log

if grep -q "Testbench failed" sim.log; then
	exit 1
fi
exit 0
